//--- verilog/hart_pkg.sv
// Shared sizes, counts and types for the multithreaded fetch front end.
// Modules refer to these by scoped names, so no file imports the package.
`default_nettype none

package hart_pkg;

    localparam int NUM_HARTS   = 4;    // Hardware threads sharing one fetch slot.
    localparam int HART_W      = 2;    // Bits in a hart id.
    localparam int IMEM_WORDS  = 256;  // Depth of the shared instruction memory.
    localparam int ADDR_W      = 8;    // Bits in a word address.
    localparam int HART_STRIDE = 64;   // Words per hart region; hart h starts at h * 64.
    localparam int OFFS_W      = 6;    // Bits of the offset inside one region.
    localparam int WORD_W      = 32;   // Bits in an instruction word.

    // Granted fetches a hart keeps the slot before the selector rotates.
    localparam int SLICE_LEN   = 11;
    localparam int CNT_W       = 4;    // Wide enough to hold SLICE_LEN itself.

    typedef logic [HART_W-1:0]    hart_id_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [NUM_HARTS-1:0] hart_mask_t;
    typedef logic [OFFS_W-1:0]    offs_t;   // Offset of a PC within its region.
    typedef logic [CNT_W-1:0]     cnt_t;    // Slice counter value.

endpackage

`default_nettype wire

//--- verilog/mem_port_if.sv
// One requester's port on the shared instruction memory.
// The requester drives a request, the arbiter answers with gnt and read data.
// A request is served in a cycle where req and gnt are both high.
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if;

    logic             req;    // Requester wants the memory this cycle.
    logic             we;     // High for a write, low for a read.
    hart_pkg::addr_t  addr;   // Word address of the access.
    hart_pkg::word_t  wdata;  // Write data, ignored on reads.
    logic             gnt;    // Arbiter serves this request in the current cycle.
    hart_pkg::word_t  rdata;  // Read data, valid the cycle after a granted read.

    // Fetch unit and program loader sit on this side.
    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    // The memory arbiter sees every requester through this side.
    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- verilog/hart_selector.sv
// Coarse-grained thread selector. Keeps the active-hart mask, counts the
// granted fetches of the current hart and rotates to the next active hart
// when the slice ends, a cache miss is reported or the current hart ends.
`timescale 1ns/100ps
`default_nettype none

module hart_selector (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               fetch_done,      // One granted fetch of cur_hart.
    input  logic               cache_miss,      // Miss strobe, forces a rotation.
    input  logic               terminate,       // Terminate strobe.
    input  hart_pkg::hart_id_t terminate_hart,  // Hart removed by terminate.
    output hart_pkg::hart_id_t cur_hart,
    output logic               fetch_stop,
    output logic               all_done
);

    hart_pkg::hart_mask_t active_mask, next_mask;
    hart_pkg::cnt_t       count, next_count;
    hart_pkg::hart_id_t   next_pick;
    logic                 slice_end, cur_killed, rotate;

    // The last fetch of a slice makes the count reach SLICE_LEN, so the
    // rotation lands in the following cycle.
    assign slice_end  = fetch_done && (count == hart_pkg::cnt_t'(hart_pkg::SLICE_LEN - 1));
    assign cur_killed = terminate && (terminate_hart == cur_hart);
    assign rotate     = slice_end || cache_miss || cur_killed;

    assign fetch_stop = (active_mask == '0);  // Nobody left to fetch for.

    // Drop the terminated hart before choosing, so it is never picked.
    always_comb begin
        next_mask = active_mask;
        if (terminate) begin
            next_mask[terminate_hart] = 1'b0;
        end
    end

    // Scan from the farthest offset down to the nearest one, so the nearest
    // active hart after cur_hart wins. Offset NUM_HARTS is cur_hart itself,
    // which keeps a lone survivor in place.
    always_comb begin
        hart_pkg::hart_id_t cand;
        next_pick = cur_hart;
        for (int i = hart_pkg::NUM_HARTS; i >= 1; i--) begin
            cand = cur_hart + hart_pkg::hart_id_t'(i);  // Wraps through the id width.
            if (next_mask[cand]) begin
                next_pick = cand;
            end
        end
    end

    always_comb begin
        if (rotate) begin
            next_count = '0;                  // A new hart starts a fresh slice.
        end else if (fetch_done) begin
            next_count = count + 1'b1;
        end else begin
            next_count = count;               // Back-pressure holds the count.
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cur_hart    <= '0;
            active_mask <= '1;                // All harts start active.
            count       <= '0;
            all_done    <= 1'b0;
        end else begin
            active_mask <= next_mask;
            count       <= next_count;
            all_done    <= fetch_stop;        // Registered copy of the empty mask.
            if (rotate) begin
                cur_hart <= next_pick;
            end
        end
    end

    // The mask and cur_hart move together, so the current hart stays active
    // until the mask runs empty. all_done follows one cycle after that.
    a_cur_active: assert property (@(posedge CLK) disable iff (!nRST)
        !fetch_stop && !all_done |-> active_mask[cur_hart])
        else $error("Current hart is not in the active mask.");

    a_count_max: assert property (@(posedge CLK) disable iff (!nRST)
        count <= hart_pkg::cnt_t'(hart_pkg::SLICE_LEN))
        else $error("Slice counter ran past SLICE_LEN.");

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
// Fetch unit with one PC per hart. Requests a read at the current hart's PC
// each cycle, advances that PC on a grant and presents the fetched word,
// with the hart and PC of the request, one cycle later.
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic               CLK,
    input  logic               nRST,
    input  hart_pkg::hart_id_t cur_hart,
    input  logic               fetch_stop,   // No active hart is left.
    input  logic               cache_miss,   // Suppresses the request this cycle.
    mem_port_if.requester      mem,
    output logic               fetch_done,   // Pulse per granted fetch.
    output logic               fetch_valid,
    output hart_pkg::hart_id_t fetch_hart,
    output hart_pkg::addr_t    fetch_pc,
    output hart_pkg::word_t    fetch_instr
);

    hart_pkg::addr_t pc [hart_pkg::NUM_HARTS];
    hart_pkg::addr_t cur_pc, pc_adv;
    hart_pkg::offs_t offs_next;
    logic            fire;

    assign cur_pc = pc[cur_hart];

    // Only the offset bits count up, so the PC wraps inside its own region.
    assign offs_next = cur_pc[hart_pkg::OFFS_W-1:0] + hart_pkg::offs_t'(1);
    assign pc_adv    = {cur_pc[hart_pkg::ADDR_W-1:hart_pkg::OFFS_W], offs_next};

    // Fetch is read only.
    assign mem.req   = !fetch_stop && !cache_miss;
    assign mem.we    = 1'b0;
    assign mem.addr  = cur_pc;
    assign mem.wdata = '0;

    assign fire       = mem.req && mem.gnt;  // The read is served this cycle.
    assign fetch_done = fire;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // Each PC starts at the base of its hart's region.
            for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
                pc[h] <= hart_pkg::addr_t'(h * hart_pkg::HART_STRIDE);
            end
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= fire;
            if (fire) begin
                pc[cur_hart] <= pc_adv;      // Without a grant the PC holds.
            end
        end
    end

    // Tag of the outstanding read, lined up with rdata in the next cycle.
    always_ff @(posedge CLK) begin
        if (fire) begin
            fetch_hart <= cur_hart;
            fetch_pc   <= cur_pc;
        end
    end

    assign fetch_instr = mem.rdata;          // Memory read data is already registered.

endmodule

`default_nettype wire

//--- verilog/program_loader.sv
// Program loader. Takes one word from the load strobe and holds a write
// request on the shared memory until the arbiter grants it.
`timescale 1ns/100ps
`default_nettype none

module program_loader (
    input  logic            CLK,
    input  logic            nRST,
    input  logic            load_valid,
    input  hart_pkg::addr_t load_addr,
    input  hart_pkg::word_t load_data,
    output logic            load_ready,  // Low while a word waits for the memory.
    mem_port_if.requester   mem
);

    logic            busy;
    hart_pkg::addr_t addr_q;
    hart_pkg::word_t data_q;

    assign load_ready = !busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
        end else if (load_valid && !busy) begin
            busy <= 1'b1;                  // Word captured, start requesting.
        end else if (mem.req && mem.gnt) begin
            busy <= 1'b0;                  // Written this cycle.
        end
    end

    always_ff @(posedge CLK) begin
        if (load_valid && !busy) begin
            addr_q <= load_addr;
            data_q <= load_data;
        end
    end

    assign mem.req   = busy;
    assign mem.we    = 1'b1;               // The loader only ever writes.
    assign mem.addr  = addr_q;
    assign mem.wdata = data_q;

    a_no_load_busy: assert property (@(posedge CLK) disable iff (!nRST)
        load_valid |-> !busy)
        else $error("Load strobe arrived while a word was pending.");

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
// Round-robin arbiter for the single memory port. A lone requester is
// granted at once; when fetch and loader both ask, the one not served
// last wins. The winner's access is steered onto the memory ports.
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic            CLK,
    input  logic            nRST,
    mem_port_if.arbiter     fetch_port,
    mem_port_if.arbiter     load_port,
    output logic            mem_en,
    output logic            mem_we,
    output hart_pkg::addr_t mem_addr,
    output hart_pkg::word_t mem_wdata,
    input  hart_pkg::word_t mem_rdata
);

    logic last_load;  // High when the loader won the last grant.
    logic gnt_fetch, gnt_load;

    assign gnt_fetch = fetch_port.req && (!load_port.req || last_load);
    assign gnt_load  = load_port.req && (!fetch_port.req || !last_load);

    assign fetch_port.gnt = gnt_fetch;
    assign load_port.gnt  = gnt_load;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_load <= 1'b0;   // Loader takes the first contested cycle.
        end else if (gnt_load) begin
            last_load <= 1'b1;
        end else if (gnt_fetch) begin
            last_load <= 1'b0;
        end
    end

    // Steer the winner. With no grant the memory is idle and keeps rdata.
    always_comb begin
        mem_en    = gnt_fetch || gnt_load;
        mem_we    = fetch_port.we;
        mem_addr  = fetch_port.addr;
        mem_wdata = fetch_port.wdata;
        if (gnt_load) begin
            mem_we    = load_port.we;
            mem_addr  = load_port.addr;
            mem_wdata = load_port.wdata;
        end
    end

    // Read data goes to both; only the one with a read in flight uses it.
    assign fetch_port.rdata = mem_rdata;
    assign load_port.rdata  = mem_rdata;

    a_one_grant: assert property (@(posedge CLK) disable iff (!nRST)
        !(gnt_fetch && gnt_load))
        else $error("Both requesters granted in one cycle.");

endmodule

`default_nettype wire

//--- verilog/imem.sv
// Instruction memory with one synchronous port. A read returns its word on
// rdata after the clock edge; a write leaves rdata unchanged.
`timescale 1ns/100ps
`default_nettype none

module imem (
    input  logic            CLK,
    input  logic            en,     // Access enable from the arbiter.
    input  logic            we,
    input  hart_pkg::addr_t addr,
    input  hart_pkg::word_t wdata,
    output hart_pkg::word_t rdata
);

    hart_pkg::word_t mem [hart_pkg::IMEM_WORDS];

    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];   // Valid in the cycle after the grant.
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/hart_fetch_top.sv
// Top level of the multithreaded fetch front end. Ties the hart selector,
// fetch unit, program loader, memory arbiter and instruction memory
// together and exposes them through plain ports.
`timescale 1ns/100ps
`default_nettype none

module hart_fetch_top (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               load_valid,
    input  hart_pkg::addr_t    load_addr,
    input  hart_pkg::word_t    load_data,
    input  logic               cache_miss,
    input  logic               terminate,
    input  hart_pkg::hart_id_t terminate_hart,
    output logic               load_ready,
    output logic               fetch_valid,
    output hart_pkg::hart_id_t fetch_hart,
    output hart_pkg::addr_t    fetch_pc,
    output hart_pkg::word_t    fetch_instr,
    output logic               all_done
);

    hart_pkg::hart_id_t cur_hart;
    logic               fetch_stop, fetch_done;
    logic               mem_en, mem_we;
    hart_pkg::addr_t    mem_addr;
    hart_pkg::word_t    mem_wdata, mem_rdata;

    mem_port_if fetch_bus ();  // Fetch unit to arbiter.
    mem_port_if load_bus ();   // Loader to arbiter.

    hart_selector i_selector (
        .CLK            (CLK),
        .nRST           (nRST),
        .fetch_done     (fetch_done),
        .cache_miss     (cache_miss),
        .terminate      (terminate),
        .terminate_hart (terminate_hart),
        .cur_hart       (cur_hart),
        .fetch_stop     (fetch_stop),
        .all_done       (all_done)
    );

    fetch_unit i_fetch (
        .CLK         (CLK),
        .nRST        (nRST),
        .cur_hart    (cur_hart),
        .fetch_stop  (fetch_stop),
        .cache_miss  (cache_miss),
        .mem         (fetch_bus.requester),
        .fetch_done  (fetch_done),
        .fetch_valid (fetch_valid),
        .fetch_hart  (fetch_hart),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    program_loader i_loader (
        .CLK        (CLK),
        .nRST       (nRST),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_ready (load_ready),
        .mem        (load_bus.requester)
    );

    mem_arbiter i_arbiter (
        .CLK        (CLK),
        .nRST       (nRST),
        .fetch_port (fetch_bus.arbiter),
        .load_port  (load_bus.arbiter),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    imem i_imem (
        .CLK   (CLK),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- tests/hart_fetch_tb.sv
// Testbench for the multithreaded fetch front end. Loads the whole memory,
// runs with random cache misses, then terminates the harts one at a time.
// A cycle-level model of the selection rules checks every fetch at negedge.
`timescale 1ns/100ps
`default_nettype none

module hart_fetch_tb;

    // Load, miss and terminate phases take about 1,300 cycles in total.
    localparam int TIMEOUT  = 20000;
    localparam int RUN_LEN  = 600;    // Cycles with random cache misses.
    localparam int GAP_LEN  = 40;     // Cycles between two terminate strobes.

    logic               CLK, nRST;
    logic               load_valid, cache_miss, terminate;
    hart_pkg::addr_t    load_addr;
    hart_pkg::word_t    load_data;
    hart_pkg::hart_id_t terminate_hart;
    logic               load_ready, fetch_valid, all_done;
    hart_pkg::hart_id_t fetch_hart;
    hart_pkg::addr_t    fetch_pc;
    hart_pkg::word_t    fetch_instr;

    hart_pkg::word_t      image [hart_pkg::IMEM_WORDS];  // Words written by the loader.
    logic [31:0]          rng;
    logic                 loaded;
    int                   cycles = 0;

    // Model state describes the cycle before the current negedge.
    hart_pkg::addr_t      pc_model [hart_pkg::NUM_HARTS];
    hart_pkg::hart_mask_t alive;
    hart_pkg::hart_id_t   sel, last_hart, term_hart_prev;
    int                   slice_cnt, run_len;
    logic                 miss_prev, term_prev, loaded_prev;

    hart_fetch_top i_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // First live hart after h in increasing id with wrap, or h if none is.
    function automatic hart_pkg::hart_id_t next_alive(input hart_pkg::hart_id_t h,
                                                      input hart_pkg::hart_mask_t m);
        int cand;
        for (int i = 1; i <= hart_pkg::NUM_HARTS; i++) begin
            cand = (int'(h) + i) % hart_pkg::NUM_HARTS;
            if (m[hart_pkg::hart_id_t'(cand)]) begin
                return hart_pkg::hart_id_t'(cand);
            end
        end
        return h;
    endfunction

    // One word further, wrapping at the end of the region that holds pc.
    function automatic hart_pkg::addr_t advance_pc(input hart_pkg::addr_t pc);
        int base;
        base = (int'(pc) / hart_pkg::HART_STRIDE) * hart_pkg::HART_STRIDE;
        return hart_pkg::addr_t'(base + (int'(pc) - base + 1) % hart_pkg::HART_STRIDE);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run stopped at cycle %0d.", cycles);
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("Error in %s: expected 0x%0h, actual 0x%0h",
                            test, expected, actual));
    endtask

    task automatic tick();
        @(posedge CLK);
        #1;                                 // Inputs change just after the edge.
    endtask

    // With two requesters the pending word wins the port within two rounds.
    task automatic wait_load_ready();
        int waited;
        waited = 0;
        while (!load_ready) begin
            if (waited >= 2) begin
                abort_run("load_ready did not return within two arbitration rounds.");
            end
            tick();
            waited++;
        end
    endtask

    task automatic retire_hart(input int h);
        terminate      = 1'b1;
        terminate_hart = hart_pkg::hart_id_t'(h);
        tick();
        terminate      = 1'b0;
        repeat (GAP_LEN) tick();            // Let the others rotate a few slices.
    endtask

    initial begin
        CLK = 1'b0;
        forever begin
            #4 CLK = ~CLK;                  // 8 ns period.
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            abort_run("Timeout: the run did not finish within the cycle limit.");
        end
    end

    always @(negedge CLK) begin : check_fetch
        hart_pkg::hart_mask_t next_mask;
        logic                 rotate;
        if (!nRST) begin
            for (int h = 0; h < hart_pkg::NUM_HARTS; h++) begin
                pc_model[hart_pkg::hart_id_t'(h)] = hart_pkg::addr_t'(h * hart_pkg::HART_STRIDE);
            end
            alive       = '1;
            sel         = '0;
            last_hart   = '0;
            slice_cnt   = 0;
            run_len     = 0;
            miss_prev   = 1'b0;
            term_prev   = 1'b0;
            loaded_prev = 1'b0;
        end else begin
            // The done level follows the active set by one cycle.
            assert (all_done == (alive == '0))
                else abort_run("all_done does not match the set of active harts.");
            assert (!(miss_prev && fetch_valid))
                else abort_run("A fetch was served in a cache-miss cycle.");
            if (loaded_prev && !miss_prev && alive != '0) begin
                assert (fetch_valid)
                    else abort_run("A lone fetch request was not granted at once.");
            end
            if (fetch_valid) begin
                assert (fetch_hart == sel)
                    else report_mismatch("hart order", 32'(sel), 32'(fetch_hart));
                assert (alive[fetch_hart])
                    else abort_run("A terminated hart was fetched.");
                assert (fetch_pc == pc_model[fetch_hart])
                    else report_mismatch("pc", 32'(pc_model[fetch_hart]), 32'(fetch_pc));
                if (loaded_prev) begin
                    assert (fetch_instr == image[fetch_pc])
                        else report_mismatch("instr", image[fetch_pc], fetch_instr);
                end
                pc_model[fetch_hart] = advance_pc(fetch_pc);
                run_len   = (fetch_hart == last_hart) ? run_len + 1 : 1;
                last_hart = fetch_hart;
                // With a second hart alive the slot must change hands in time.
                assert (run_len <= hart_pkg::SLICE_LEN || $countones(alive) == 1)
                    else abort_run("A hart kept the fetch slot past its slice.");
            end
            next_mask = alive;
            if (term_prev) begin
                next_mask[term_hart_prev] = 1'b0;       // Gone from the next cycle on.
            end
            rotate = (fetch_valid && slice_cnt == hart_pkg::SLICE_LEN - 1) || miss_prev
                     || (term_prev && term_hart_prev == sel);
            if (rotate) begin
                sel       = next_alive(sel, next_mask);
                slice_cnt = 0;
            end else if (fetch_valid) begin
                slice_cnt = slice_cnt + 1;
            end
            alive          = next_mask;
            miss_prev      = cache_miss;                // Inputs of this cycle.
            term_prev      = terminate;
            term_hart_prev = terminate_hart;
            loaded_prev    = loaded;
        end
    end

    initial begin
        nRST           = 1'b0;
        load_valid     = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        cache_miss     = 1'b0;
        terminate      = 1'b0;
        terminate_hart = '0;
        loaded         = 1'b0;
        rng            = 32'd72;
        for (int a = 0; a < hart_pkg::IMEM_WORDS; a++) begin
            rng = xorshift(rng);
            image[hart_pkg::addr_t'(a)] = {rng[31:8], hart_pkg::addr_t'(a)};
        end
        repeat (10) tick();
        nRST = 1'b1;
        assert (load_ready)
            else abort_run("load_ready is low after reset.");

        // Fill the memory while the fetch unit competes for the port.
        for (int a = 0; a < hart_pkg::IMEM_WORDS; a++) begin
            wait_load_ready();
            load_valid = 1'b1;
            load_addr  = hart_pkg::addr_t'(a);
            load_data  = image[hart_pkg::addr_t'(a)];
            tick();
            load_valid = 1'b0;
            assert (!load_ready)
                else abort_run("load_ready stayed high while a word was pending.");
        end
        wait_load_ready();                  // The last word is still pending.
        loaded = 1'b1;

        repeat (RUN_LEN) begin
            rng        = xorshift(rng);
            cache_miss = (rng[2:0] == 3'd0);  // Roughly one miss in eight cycles.
            tick();
        end
        cache_miss = 1'b0;

        retire_hart(2);
        retire_hart(0);
        retire_hart(3);
        retire_hart(1);
        assert (all_done)
            else abort_run("all_done is low after every hart was terminated.");
        repeat (20) tick();                 // fetch_valid must stay low here.

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/hart_pkg.sv
verilog/mem_port_if.sv
verilog/hart_selector.sv
verilog/fetch_unit.sv
verilog/program_loader.sv
verilog/mem_arbiter.sv
verilog/imem.sv
verilog/hart_fetch_top.sv
tests/hart_fetch_tb.sv

//--- run.sh
#!/bin/sh
# Builds the fetch front end and its testbench with Verilator, then runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f verilog.f --top-module hart_fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/Vhart_fetch_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status."
fi
exit $status
